// File: pixel_readout_top.f
+incdir+.
pixel_readout_pkg.sv
scan_arbiter.sv
pixel_level_0.sv
event_fifo.sv
event_readout.sv
pixel_readout_top.sv
tb_clock_gen.sv
tb_pixel_readout.sv

// File: run_sim.sh
#!/bin/sh
# Builds the pixel readout testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --timescale 1ns/100ps --top-module tb_pixel_readout \
    -f pixel_readout_top.f -o tb_pixel_readout_sim \
    && ./obj_dir/tb_pixel_readout_sim > sim.log 2>&1 \
    || { echo "Simulation could not be built or run"; exit 1; }
cat sim.log
grep -q "^Result: PASSED$" sim.log \
    && echo "Testbench reported success" \
    || { echo "Testbench reported failure"; exit 1; }

// File: tb_pixel_readout.sv
`timescale 1ns/100ps
`default_nettype none
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Pixel readout testbench
// Random pixel patterns against a pixel model and a queue of
// expected event words, with random downstream stall
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "pixel_readout_config.svh"

module tb_pixel_readout;
    import pixel_readout_pkg::*;

    typedef logic [`PIX_ROWS-1:0][`PIX_COLS-1:0] grid_t;

    localparam int N_STALL        = 6;                  // High density patterns under stall
    localparam int N_ABORT        = 2;                  // Patterns with an enable drop
    localparam int N_PATTERNS     = N_STALL + N_ABORT + 4;  // Plus idle, single, zero, ones
    localparam int TIMEOUT_CYCLES = N_PATTERNS * (`PIX_ROWS * `PIX_COLS * 3 + 20);

    logic        clk;
    logic        reset;
    logic        enable;
    grid_t       pix_req;                               // Pixel model, drives the DUT
    logic        stall;
    grid_t       pix_gnt;
    logic        req;
    logic        grp_release;
    logic        evt_valid;
    logic        evt_marker;
    pix_addr_t   evt_x;
    pix_addr_t   evt_y;
    evt_count_t  evt_count;

    logic [31:0] lfsr_state;
    logic        stall_mode;                            // Random stall while set
    logic        released;                              // Group release kept last cycle
    grid_t       smp_gnt;                               // Outputs sampled on the falling edge
    logic        smp_valid;
    logic        smp_release;
    string       test_name;
    int          checks;
    int          errors;
    int          cycle_count = 0;
    event_word_t exp_word_q[$];                         // Expected words in output order
    evt_count_t  exp_cnt_q[$];                          // Count expected with each word

    tb_clock_gen #(.PERIOD_NS(100), .RESET_CYCLES(2)) i_clock_gen
    (
        .clk_o   (clk),
        .reset_o (reset)
    );

    pixel_readout_top i_dut
    (
        .clk_i         (clk),
        .reset_i       (reset),
        .enable_i      (enable),
        .pix_req_i     (pix_req),
        .stall_i       (stall),
        .pix_gnt_o     (pix_gnt),
        .req_o         (req),
        .grp_release_o (grp_release),
        .evt_valid_o   (evt_valid),
        .evt_marker_o  (evt_marker),
        .evt_x_o       (evt_x),
        .evt_y_o       (evt_y),
        .evt_count_o   (evt_count)
    );

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_step(lfsr_state);         // One step per bit
            v          = {v[30:0], lfsr_state[0]};
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        checks++;
        if (exp !== act)
        begin
            errors++;
            $display("[FAIL] %s %s: expected %b, actual %b", test_name, name, exp, act);
        end
    endtask

    task automatic check_addr(input string name, input pix_addr_t exp, input pix_addr_t act);
        checks++;
        if (exp !== act)
        begin
            errors++;
            $display("[FAIL] %s %s: expected %0d, actual %0d", test_name, name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input evt_count_t exp, input evt_count_t act);
        checks++;
        if (exp !== act)
        begin
            errors++;
            $display("[FAIL] %s %s: expected %0d, actual %0d", test_name, name, exp, act);
        end
    endtask

    // Density in quarters, a pixel is set when two drawn bits fall below it
    task automatic make_pattern(input int density, output grid_t p);
        logic [31:0] v;
        for (int r = 0; r < `PIX_ROWS; r++)
        begin
            for (int c = 0; c < `PIX_COLS; c++)
            begin
                draw_bits(2, v);
                p[r][c] = (int'(v) < density);
            end
        end
    endtask

    // Sample on the falling edge, update the models, then drive the next cycle
    task automatic run_cycle(input logic en);
        event_word_t w;
        evt_count_t  c;
        logic [31:0] v;
        @(negedge clk);
        smp_gnt     = pix_gnt;
        smp_valid   = evt_valid;
        smp_release = grp_release;
        check_flag("req_o", |pix_req, req);
        if (smp_valid)
        begin
            if (exp_word_q.size() == 0)
            begin
                errors++;
                $display("%s: an event word came out when none was expected", test_name);
            end
            else
            begin
                w = exp_word_q.pop_front();
                c = exp_cnt_q.pop_front();
                check_flag("evt_marker_o", w.marker, evt_marker);
                if (w.marker)
                    check_count("evt_count_o", c, evt_count);
                else
                begin
                    check_addr("evt_x_o", w.x, evt_x);
                    check_addr("evt_y_o", w.y, evt_y);
                end
            end
        end
        released = en & smp_release;                    // Dropping enable cancels the marker
        if (en && (smp_gnt != '0))
        begin
            check_flag("pix_gnt_o one-hot", 1'b1, $onehot(smp_gnt));
            check_flag("pix_gnt_o on requester", 1'b1, (smp_gnt & ~pix_req) == '0);
            pix_req = pix_req & ~smp_gnt;               // Pixel drops its request once served
        end
        enable = en;
        if (stall_mode)
        begin
            draw_bits(1, v);
            stall = v[0];
        end
        else
            stall = 1'b0;
    endtask

    // One pass over a pattern, then drain until every expected word is out
    task automatic run_pattern(input string name, input grid_t p, input logic stall_en,
                               input int abort_at);
        event_word_t w;
        int          n;
        int          cyc;
        test_name  = name;
        stall_mode = stall_en;
        pix_req    = p;
        n          = 0;
        for (int r = 0; r < `PIX_ROWS; r++)
        begin
            for (int c = 0; c < `PIX_COLS; c++)
            begin
                if (p[r][c])
                begin
                    w.marker = 1'b0;                    // Row-major ascending order
                    w.x      = pix_addr_t'(r);
                    w.y      = pix_addr_t'(c);
                    exp_word_q.push_back(w);
                    exp_cnt_q.push_back(evt_count_t'(0));
                    n++;
                end
            end
        end
        w.marker = 1'b1;
        w.x      = '0;
        w.y      = '0;
        exp_word_q.push_back(w);
        exp_cnt_q.push_back(evt_count_t'(n));           // Marker closes the group
        cyc      = 0;
        released = 1'b0;
        while (!released)
        begin
            if (cyc == abort_at)
            begin
                run_cycle(1'b0);                        // Enable low for two cycles
                run_cycle(1'b0);
            end
            run_cycle(1'b1);
            cyc++;
        end
        check_flag("every request granted", 1'b1, pix_req == '0);
        while (exp_word_q.size() != 0)
            run_cycle(1'b0);
        repeat (3) run_cycle(1'b0);                     // Nothing more may come out
        stall_mode = 1'b0;
    endtask

    initial
    begin
        grid_t       p;
        logic [31:0] v;
        enable     = 1'b0;
        stall      = 1'b0;
        pix_req    = '0;
        lfsr_state = 32'h728c;
        stall_mode = 1'b0;
        released   = 1'b0;
        checks     = 0;
        errors     = 0;
        test_name  = "reset";
        @(negedge reset);

        test_name = "idle_after_reset";
        repeat (8)
        begin
            run_cycle(1'b0);
            check_flag("evt_valid_o low", 1'b0, smp_valid);
            check_flag("grp_release_o low", 1'b0, smp_release);
            check_flag("pix_gnt_o low", 1'b1, smp_gnt == '0);
            make_pattern(2, pix_req);                   // Requests change, enable stays low
        end
        pix_req = '0;

        make_pattern(2, p);
        run_pattern("single_no_stall", p, 1'b0, -1);
        run_pattern("all_zero", '0, 1'b0, -1);
        run_pattern("all_ones", '1, 1'b0, -1);

        for (int i = 0; i < N_STALL; i++)
        begin
            make_pattern(3, p);
            run_pattern("stall_high_density", p, 1'b1, -1);
        end

        for (int i = 0; i < N_ABORT; i++)
        begin
            make_pattern(3, p);
            draw_bits(4, v);
            run_pattern("enable_drop", p, i[0], 6 + int'(v));   // Drop lands inside the pass
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

    // Run length guard
    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES)
        begin
            $display("Timeout in %s: the run did not end within %0d cycles",
                     test_name, TIMEOUT_CYCLES);
            $display("Checks: %0d, errors: %0d", checks, errors);
            $display("Result: FAILED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
`timescale 1ns/100ps
`default_nettype none
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench clock and reset generator
// Free running clock, reset released on a falling edge
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module tb_clock_gen
#(
    parameter int PERIOD_NS    = 100,                   // Clock period
    parameter int RESET_CYCLES = 2                      // Rising edges under reset
)
(
    output logic clk_o,                                 // Testbench clock
    output logic reset_o                                // Active high reset
);

    initial
    begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    initial
    begin
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);                               // Release away from the active edge
        reset_o = 1'b0;
    end

endmodule

`default_nettype wire

// File: pixel_readout_top.sv
`timescale 1ns/100ps
`default_nettype none
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Pixel readout top
// Pixel arbiter feeding the event FIFO and the readout stage
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "pixel_readout_config.svh"

module pixel_readout_top
(
    input  logic                                clk_i,          // Clock
    input  logic                                reset_i,        // Async reset, active high
    input  logic                                enable_i,       // Arbitration enable level
    input  logic [`PIX_ROWS-1:0][`PIX_COLS-1:0] pix_req_i,      // Pixel request grid
    input  logic                                stall_i,        // Downstream stall level
    output logic [`PIX_ROWS-1:0][`PIX_COLS-1:0] pix_gnt_o,      // One-hot pixel grant
    output logic                                req_o,          // Any pixel requesting
    output logic                                grp_release_o,  // Pass end pulse
    output logic                                evt_valid_o,    // Event word strobe
    output logic                                evt_marker_o,
    output pixel_readout_pkg::pix_addr_t        evt_x_o,
    output pixel_readout_pkg::pix_addr_t        evt_y_o,
    output pixel_readout_pkg::evt_count_t       evt_count_o
);
    import pixel_readout_pkg::*;

    logic        push;
    logic        marker;
    pix_addr_t   x_add;
    pix_addr_t   y_add;
    event_word_t push_word;
    logic        fifo_full;
    logic        fifo_empty;
    logic        pop;
    event_word_t head_word;

    // Marker words keep whatever address is current
    assign push_word.marker = marker;
    assign push_word.x      = x_add;
    assign push_word.y      = y_add;

    pixel_level_0 u_pixel_level_0
    (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .enable_i      (enable_i),
        .hold_i        (fifo_full),
        .req_i         (pix_req_i),
        .gnt_o         (pix_gnt_o),
        .x_add_o       (x_add),
        .y_add_o       (y_add),
        .push_o        (push),
        .marker_o      (marker),
        .req_o         (req_o),
        .grp_release_o (grp_release_o)
    );

    event_fifo #(.DEPTH(`EVT_FIFO_DEPTH)) u_event_fifo
    (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .push_i      (push),
        .push_data_i (push_word),
        .pop_i       (pop),
        .head_o      (head_word),
        .full_o      (fifo_full),
        .empty_o     (fifo_empty)
    );

    event_readout u_event_readout
    (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .stall_i      (stall_i),
        .empty_i      (fifo_empty),
        .head_i       (head_word),
        .pop_o        (pop),
        .evt_valid_o  (evt_valid_o),
        .evt_marker_o (evt_marker_o),
        .evt_x_o      (evt_x_o),
        .evt_y_o      (evt_y_o),
        .evt_count_o  (evt_count_o)
    );

endmodule

`default_nettype wire

// File: event_readout.sv
`timescale 1ns/100ps
`default_nettype none
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Event readout
// Drains the event FIFO under stall and reports the number
// of events per group on each marker word
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module event_readout
(
    input  logic                           clk_i,       // Clock
    input  logic                           reset_i,     // Async reset, active high
    input  logic                           stall_i,     // Downstream not ready
    input  logic                           empty_i,     // FIFO empty
    input  pixel_readout_pkg::event_word_t head_i,      // FIFO head word
    output logic                           pop_o,       // Take the head word
    output logic                           evt_valid_o, // Output word strobe
    output logic                           evt_marker_o,
    output pixel_readout_pkg::pix_addr_t   evt_x_o,
    output pixel_readout_pkg::pix_addr_t   evt_y_o,
    output pixel_readout_pkg::evt_count_t  evt_count_o  // Events in the closed group
);
    import pixel_readout_pkg::*;

    evt_count_t cnt_q;                                  // Events since last marker

    assign pop_o = ~stall_i & ~empty_i;

    // Strobe, marker flag and group counter
    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            evt_valid_o  <= 1'b0;
            evt_marker_o <= 1'b0;
            evt_count_o  <= '0;
            cnt_q        <= '0;
        end
        else
        begin
            evt_valid_o <= pop_o;                       // One cycle after the pop
            if (pop_o)
            begin
                evt_marker_o <= head_i.marker;
                if (head_i.marker)
                begin
                    evt_count_o <= cnt_q;               // Close the group
                    cnt_q       <= '0;
                end
                else
                begin
                    cnt_q <= cnt_q + evt_count_t'(1);
                end
            end
        end
    end

    // Address payload
    always_ff @(posedge clk_i)
    begin
        if (pop_o)
        begin
            evt_x_o <= head_i.x;
            evt_y_o <= head_i.y;
        end
    end

endmodule

`default_nettype wire

// File: event_fifo.sv
`timescale 1ns/100ps
`default_nettype none
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Event FIFO
// Circular buffer of event words with full and empty levels
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "pixel_readout_config.svh"

module event_fifo
#(
    parameter int DEPTH = `EVT_FIFO_DEPTH               // Number of entries
)
(
    input  logic                           clk_i,       // Clock
    input  logic                           reset_i,     // Async reset, active high
    input  logic                           push_i,      // Write strobe
    input  pixel_readout_pkg::event_word_t push_data_i, // Word to write
    input  logic                           pop_i,       // Read strobe
    output pixel_readout_pkg::event_word_t head_o,      // Oldest word
    output logic                           full_o,
    output logic                           empty_o
);
    import pixel_readout_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    event_word_t      mem [DEPTH];                      // Storage
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;                          // Occupancy
    logic             wr_en;
    logic             rd_en;

    // Wraps at DEPTH, so any depth works
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + PTR_W'(1);
    endfunction

    assign full_o  = (count_q == CNT_W'(DEPTH));
    assign empty_o = (count_q == '0);
    assign wr_en   = push_i & ~full_o;                  // Writes into a full FIFO are dropped
    assign rd_en   = pop_i & ~empty_o;
    assign head_o  = mem[rd_ptr_q];

    always_ff @(posedge clk_i)
    begin
        if (wr_en)
        begin
            mem[wr_ptr_q] <= push_data_i;
        end
    end

    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end
        else
        begin
            if (wr_en)
                wr_ptr_q <= ptr_inc(wr_ptr_q);
            if (rd_en)
                rd_ptr_q <= ptr_inc(rd_ptr_q);
            case ({wr_en, rd_en})
                2'b10:   count_q <= count_q + CNT_W'(1);
                2'b01:   count_q <= count_q - CNT_W'(1);
                default: count_q <= count_q;            // Both or neither
            endcase
        end
    end

endmodule

`default_nettype wire

// File: pixel_level_0.sv
`timescale 1ns/100ps
`default_nettype none
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Pixel level 0 arbiter
// Picks a requesting row, then walks its requesting columns,
// one grant per cycle, and flags the end of each pass
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "pixel_readout_config.svh"

module pixel_level_0
(
    input  logic                                clk_i,          // Clock
    input  logic                                reset_i,        // Async reset, active high
    input  logic                                enable_i,       // Arbitration enable level
    input  logic                                hold_i,         // FIFO full, freeze everything
    input  logic [`PIX_ROWS-1:0][`PIX_COLS-1:0] req_i,          // Pixel request grid
    output logic [`PIX_ROWS-1:0][`PIX_COLS-1:0] gnt_o,          // One-hot pixel grant
    output pixel_readout_pkg::pix_addr_t        x_add_o,        // Granted row
    output pixel_readout_pkg::pix_addr_t        y_add_o,        // Granted column
    output logic                                push_o,         // Write one word to the FIFO
    output logic                                marker_o,       // Pushed word is a group marker
    output logic                                req_o,          // Any pixel requesting
    output logic                                grp_release_o   // Full pass has ended
);
    import pixel_readout_pkg::*;

    typedef enum logic [1:0]
    {
        st_idle = 2'b00,                                // Arbiters held at pass start
        st_row  = 2'b01,                                // Row arbiter picks next row
        st_col  = 2'b10                                 // Column arbiter walks the row
    } state_t;

    state_t               state_q;
    state_t               state_d;
    logic [`PIX_ROWS-1:0] row_req;                      // OR of each row
    logic [`PIX_ROWS-1:0] row_gnt;                      // Granted row, one-hot
    logic [`PIX_COLS-1:0] col_req;                      // Requests of the granted row
    logic [`PIX_COLS-1:0] col_gnt;                      // Granted column, one-hot
    pix_addr_t            row_addr;
    pix_addr_t            col_addr;
    logic                 run;                          // Enabled and not held
    logic                 row_en;
    logic                 col_en;
    logic                 row_refresh;
    logic                 col_refresh;
    logic                 row_done;                     // No row left in this pass
    logic                 col_done;                     // No column left in this row
    logic                 col_vld;                      // A pixel grant is shown this cycle

    assign req_o = |req_i;

    always_comb
    begin
        for (int i = 0; i < `PIX_ROWS; i++)
        begin
            row_req[i] = |req_i[i];
        end
    end

    assign col_req = req_i[row_addr];                   // Row held by the row arbiter

    assign run         = enable_i & ~hold_i;
    assign row_en      = run & (state_q == st_row);
    assign col_en      = run & (state_q == st_col);
    assign row_refresh = ~enable_i | (state_q == st_idle);
    assign col_refresh = ~enable_i | (state_q != st_col);   // Each row starts at column 0

    // Next state
    always_comb
    begin
        state_d = state_q;
        if (!enable_i)
        begin
            state_d = st_idle;                          // Abort the pass
        end
        else if (!hold_i)
        begin
            case (state_q)
                st_idle: state_d = st_row;
                st_row:  state_d = row_done ? st_idle : st_col;
                st_col:  state_d = col_done ? st_row : st_col;
                default: state_d = st_idle;
            endcase
        end
    end

    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            state_q <= st_idle;
        end
        else
        begin
            state_q <= state_d;
        end
    end

    // Column grant is registered, masked while held
    assign col_vld = run & (state_q == st_col) & (|col_gnt);

    always_comb
    begin
        for (int i = 0; i < `PIX_ROWS; i++)
        begin
            for (int j = 0; j < `PIX_COLS; j++)
            begin
                gnt_o[i][j] = col_vld & row_gnt[i] & col_gnt[j];
            end
        end
    end

    assign x_add_o       = row_addr;
    assign y_add_o       = col_addr;
    assign push_o        = col_vld | row_done;          // Pixel word or marker word
    assign marker_o      = row_done;
    assign grp_release_o = row_done;

    scan_arbiter #(.WIDTH(`PIX_ROWS)) row_arb
    (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .enable_i  (row_en),
        .refresh_i (row_refresh),
        .req_i     (row_req),
        .gnt_o     (row_gnt),
        .addr_o    (row_addr),
        .done_o    (row_done)
    );

    scan_arbiter #(.WIDTH(`PIX_COLS)) col_arb
    (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .enable_i  (col_en),
        .refresh_i (col_refresh),
        .req_i     (col_req),
        .gnt_o     (col_gnt),
        .addr_o    (col_addr),
        .done_o    (col_done)
    );

endmodule

`default_nettype wire

// File: scan_arbiter.sv
`timescale 1ns/100ps
`default_nettype none
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Scan arbiter
// One pass over the requests in ascending index order,
// one registered grant per enabled cycle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module scan_arbiter
#(
    parameter int WIDTH = 8                             // Number of request lines
)
(
    input  logic                         clk_i,         // Clock
    input  logic                         reset_i,       // Async reset, active high
    input  logic                         enable_i,      // Advance one grant per cycle
    input  logic                         refresh_i,     // Restart the pass at index 0
    input  logic [WIDTH-1:0]             req_i,         // Request levels
    output logic [WIDTH-1:0]             gnt_o,         // One-hot registered grant
    output pixel_readout_pkg::pix_addr_t addr_o,        // Index of the granted line
    output logic                         done_o         // No request left above pointer
);
    import pixel_readout_pkg::*;

    localparam int PTR_W = $clog2(WIDTH + 1);          // Pointer runs 0 to WIDTH

    logic [PTR_W-1:0] ptr_q;                            // Lowest index still open in this pass
    logic [PTR_W-1:0] sel_idx;                          // Index picked this cycle
    logic [WIDTH-1:0] sel_oh;                           // Same pick, one-hot
    logic             found;                            // Some request at or above pointer

    // Lowest set request at or above the pointer
    // The loop runs downward so the last hit is the lowest index
    always_comb
    begin
        found   = 1'b0;
        sel_idx = '0;
        sel_oh  = '0;
        for (int i = WIDTH - 1; i >= 0; i--)
        begin
            if (req_i[i] && (PTR_W'(i) >= ptr_q))
            begin
                found   = 1'b1;
                sel_idx = PTR_W'(i);
                sel_oh  = WIDTH'(1) << i;
            end
        end
    end

    assign done_o = enable_i & ~found;                  // Pass end seen while enabled

    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            ptr_q  <= '0;
            gnt_o  <= '0;
            addr_o <= '0;
        end
        else if (refresh_i)
        begin
            ptr_q  <= '0;                               // Back to index 0
            gnt_o  <= '0;
            addr_o <= '0;
        end
        else if (enable_i)
        begin
            if (found)
            begin
                ptr_q  <= sel_idx + PTR_W'(1);          // Skip past the granted line
                gnt_o  <= sel_oh;
                addr_o <= pix_addr_t'(sel_idx);
            end
            else
            begin
                gnt_o  <= '0;                           // Pass over, pointer stays put
            end
        end
    end

endmodule

`default_nettype wire

// File: pixel_readout_pkg.sv
`default_nettype none
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Pixel readout package
// Address, event word and event count types
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "pixel_readout_config.svh"

package pixel_readout_pkg;

    // Must hold a full array of events in one group
    localparam int EVT_CNT_W = $clog2(`PIX_ROWS * `PIX_COLS + 1);

    typedef logic [`PIX_ADD_W-1:0] pix_addr_t;         // One row or column address

    // Word stored in the event FIFO
    typedef struct packed
    {
        logic      marker;                              // Set on group marker words
        pix_addr_t x;                                   // Row address
        pix_addr_t y;                                   // Column address
    } event_word_t;

    typedef logic [EVT_CNT_W-1:0] evt_count_t;         // Events in one group

endpackage

`default_nettype wire

// File: pixel_readout_config.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Pixel readout configuration
// Array size, address width and event buffer depth
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef PIXEL_READOUT_CONFIG_SVH
`define PIXEL_READOUT_CONFIG_SVH

// Pixel array geometry
`define PIX_ROWS        8           // Rows in the pixel array
`define PIX_COLS        8           // Columns in the pixel array

// Address of one row or one column
`define PIX_ADD_W       3           // Enough for 8 rows or 8 columns

// Event buffer between arbiter and readout
`define EVT_FIFO_DEPTH  8           // Entries in the event FIFO

`endif
